/* hw/rbe_pkg.sv */
////////////////////
// rbe package
// geometry, payload types and engine FSM states shared by the
// binary-convolution streaming engine
////////////////////

package rbe_pkg;

  // channels per pixel, also width of one weight mask
  localparam int unsigned TP            = 4;
  // pixels per row and rows per patch in full filter mode
  localparam int unsigned FEAT_BUF_SIZE = 3;
  // rows and pixels kept in reduced filter mode
  localparam int unsigned FEAT_BUF_MIN  = 2;
  // bit planes per activation
  localparam int unsigned BLOCK_SIZE    = 2;
  // output columns of the binconv array
  localparam int unsigned NR_COLUMN     = 3;

  // one bit plane of one pixel row, pixel 0 in the low bits
  typedef logic [FEAT_BUF_SIZE-1:0][TP-1:0] feat_beat_t;
  // one channel mask per output column
  typedef logic [NR_COLUMN-1:0][TP-1:0] weight_word_t;
  // full patch indexed as [bit][row][pixel][channel]
  typedef logic [BLOCK_SIZE-1:0][FEAT_BUF_SIZE-1:0][FEAT_BUF_SIZE-1:0][TP-1:0] patch_t;
  // unsigned column sum, max 108 for this geometry
  typedef logic [7:0] result_t;
  typedef logic [NR_COLUMN-1:0] col_en_t;

  typedef logic [1:0] bit_idx_t;
  typedef logic [1:0] row_idx_t;
  typedef logic [1:0] col_idx_t;

  typedef enum logic [1:0] {GATHER, COMPUTE, DRAIN} engine_state_t;

endpackage

/* hw/engine_ctrl_if.sv */
////////////////////
// engine control bundle
// strobes and mode from the FSM, indices and flags from the counter
////////////////////

`timescale 1ns/1ps

interface engine_ctrl_if;
  import rbe_pkg::*;

  // driven by engine_ctrl
  logic     gather_en;
  logic     beat_fire;
  logic     compute_fire;
  logic     out_fire;
  logic     fs_full;
  col_en_t  col_en;
  // driven by patch_counter
  bit_idx_t bit_idx;
  row_idx_t row_idx;
  col_idx_t col_idx;
  logic     patch_done;
  logic     drain_done;

  modport ctrl (
    output gather_en, beat_fire, compute_fire, out_fire, fs_full, col_en,
    input  bit_idx, row_idx, col_idx, patch_done, drain_done
  );
  modport cnt (
    input  gather_en, beat_fire, out_fire, fs_full,
    output bit_idx, row_idx, col_idx, patch_done, drain_done
  );
  modport dp (input beat_fire, compute_fire, fs_full, col_en, bit_idx, row_idx, col_idx);

endinterface

/* hw/stream_fifo.sv */
////////////////////
// stream fifo
// small valid/ready buffer, circular storage with a fill count
////////////////////

`timescale 1ns/1ps

module stream_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic push_valid_i,
  input  T     push_data_i,
  output logic push_ready_o,
  output logic pop_valid_o,
  output T     pop_data_o,
  input  logic pop_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push, pop;

  // no bypass, a pushed entry shows up one cycle later
  assign push_ready_o = (count_q != CNT_FULL);
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      // simultaneous push and pop keeps the level
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

  a_fill_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CNT_FULL);

endmodule

/* hw/patch_counter.sv */
////////////////////
// patch counter
// bit-index and pixel-row position of the incoming beat,
// output column position of the result stream
////////////////////

`timescale 1ns/1ps

module patch_counter (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       clear_i,
  engine_ctrl_if.cnt ctrl
);
  import rbe_pkg::*;

  localparam bit_idx_t BIT_LAST = bit_idx_t'(BLOCK_SIZE - 1);
  localparam col_idx_t COL_LAST = col_idx_t'(NR_COLUMN - 1);

  row_idx_t row_last;
  logic     bit_wrap;

  // reduced mode stops one row short of the full buffer
  assign row_last = ctrl.fs_full ? row_idx_t'(FEAT_BUF_SIZE - 1) : row_idx_t'(FEAT_BUF_MIN - 1);
  assign bit_wrap = (ctrl.bit_idx == BIT_LAST);

  // position flags, qualified by the fire strobes in the FSM
  assign ctrl.patch_done = bit_wrap && (ctrl.row_idx == row_last);
  assign ctrl.drain_done = (ctrl.col_idx == COL_LAST);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl.bit_idx <= '0;
      ctrl.row_idx <= '0;
      ctrl.col_idx <= '0;
    end else if (clear_i) begin
      ctrl.bit_idx <= '0;
      ctrl.row_idx <= '0;
      ctrl.col_idx <= '0;
    end else begin
      // bit index innermost, row steps once all planes of a row are in
      if (ctrl.beat_fire) begin
        ctrl.bit_idx <= bit_wrap ? '0 : ctrl.bit_idx + 1'b1;
        if (bit_wrap) ctrl.row_idx <= (ctrl.row_idx == row_last) ? '0 : ctrl.row_idx + 1'b1;
      end
      if (ctrl.out_fire) ctrl.col_idx <= ctrl.drain_done ? '0 : ctrl.col_idx + 1'b1;
    end
  end

  // in range, and parked at zero whenever features are not gathered
  a_bit_idx_range: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (ctrl.bit_idx <= BIT_LAST) &&
    (ctrl.gather_en || (ctrl.bit_idx == '0 && ctrl.row_idx == '0)));

endmodule

/* hw/engine_ctrl.sv */
////////////////////
// engine control
// gather/compute/drain FSM, fire strobes and per-patch mode
////////////////////

`timescale 1ns/1ps

module engine_ctrl (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             fs_full_i,
  input  rbe_pkg::col_en_t col_en_i,
  input  logic             feat_valid_i,
  output logic             feat_pop_o,
  input  logic             weight_valid_i,
  output logic             weight_pop_o,
  input  logic             conv_ready_i,
  output logic             conv_valid_o,
  output logic             conv_last_o,
  output logic             busy_o,
  engine_ctrl_if.ctrl      ctrl
);
  import rbe_pkg::*;

  engine_state_t state_q, state_d;
  logic          fs_full_q;
  col_en_t       col_en_q;
  logic          patch_start, mid_patch;

  // counter at the origin while gathering, mode comes straight from the inputs
  assign mid_patch   = (ctrl.bit_idx != '0) || (ctrl.row_idx != '0);
  assign patch_start = ctrl.gather_en && !mid_patch;

  ////////////////////
  // strobes
  ////////////////////
  assign ctrl.gather_en    = (state_q == GATHER);
  assign feat_pop_o        = ctrl.gather_en && feat_valid_i;
  assign ctrl.beat_fire    = feat_pop_o;
  assign weight_pop_o      = (state_q == COMPUTE) && weight_valid_i;
  assign ctrl.compute_fire = weight_pop_o;
  assign conv_valid_o      = (state_q == DRAIN);
  assign conv_last_o       = conv_valid_o && ctrl.drain_done;
  assign ctrl.out_fire     = conv_valid_o && conv_ready_i;
  assign ctrl.fs_full      = patch_start ? fs_full_i : fs_full_q;
  assign ctrl.col_en       = patch_start ? col_en_i : col_en_q;
  assign busy_o            = !ctrl.gather_en || mid_patch;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      GATHER:  if (ctrl.beat_fire && ctrl.patch_done) state_d = COMPUTE;
      COMPUTE: if (ctrl.compute_fire) state_d = DRAIN;
      DRAIN:   if (ctrl.out_fire && ctrl.drain_done) state_d = GATHER;
      default: state_d = GATHER;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= GATHER;
      fs_full_q <= 1'b0;
      col_en_q  <= '0;
    end else if (clear_i) begin
      state_q   <= GATHER;
      fs_full_q <= 1'b0;
      col_en_q  <= '0;
    end else begin
      state_q <= state_d;
      // sampled on the first accepted beat of a patch
      if (patch_start && feat_valid_i) begin
        fs_full_q <= fs_full_i;
        col_en_q  <= col_en_i;
      end
    end
  end

  a_valid_in_drain: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    conv_valid_o |-> (state_q == DRAIN) && (ctrl.col_idx <= col_idx_t'(NR_COLUMN - 1)));

endmodule

/* hw/patch_buffer.sv */
////////////////////
// patch buffer
// collects bit planes per pixel row, silences what reduced mode drops
////////////////////

`timescale 1ns/1ps

module patch_buffer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  rbe_pkg::feat_beat_t beat_i,
  engine_ctrl_if.dp           ctrl,
  output rbe_pkg::patch_t     patch_o
);
  import rbe_pkg::*;

  localparam int unsigned BIT_SEL_W = (BLOCK_SIZE > 1) ? $clog2(BLOCK_SIZE) : 1;

  patch_t     patch_q;
  feat_beat_t beat_masked;
  logic       first_beat;

  assign first_beat = (ctrl.bit_idx == '0) && (ctrl.row_idx == '0);
  assign patch_o    = patch_q;

  // trailing pixels only count in full mode
  always_comb begin
    for (int p = 0; p < FEAT_BUF_SIZE; p++) begin
      beat_masked[p] = (ctrl.fs_full || p < FEAT_BUF_MIN) ? beat_i[p] : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      patch_q <= '0;
    end else if (clear_i) begin
      patch_q <= '0;
    end else if (ctrl.beat_fire) begin
      // rows beyond the reduced window are never written, wipe them up front
      if (first_beat && !ctrl.fs_full) begin
        for (int b = 0; b < BLOCK_SIZE; b++) begin
          for (int r = FEAT_BUF_MIN; r < FEAT_BUF_SIZE; r++) patch_q[b][r] <= '0;
        end
      end
      patch_q[ctrl.bit_idx[BIT_SEL_W-1:0]][ctrl.row_idx] <= beat_masked;
    end
  end

endmodule

/* hw/binconv_array.sv */
////////////////////
// binconv array
// masked popcount per output column, weighted by bit plane,
// results held for the serial drain
////////////////////

`timescale 1ns/1ps

module binconv_array (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  rbe_pkg::patch_t       patch_i,
  input  rbe_pkg::weight_word_t weight_i,
  engine_ctrl_if.dp             ctrl,
  output rbe_pkg::result_t      conv_data_o
);
  import rbe_pkg::*;

  result_t col_sum [NR_COLUMN];
  result_t res_q   [NR_COLUMN];

  ////////////////////
  // column sums
  ////////////////////
  always_comb begin
    logic [TP-1:0] mask;
    result_t       acc;
    for (int c = 0; c < NR_COLUMN; c++) begin
      // disabled column sees an all-zero mask
      mask = ctrl.col_en[c] ? weight_i[c] : '0;
      acc  = '0;
      for (int b = 0; b < BLOCK_SIZE; b++) begin
        for (int r = 0; r < FEAT_BUF_SIZE; r++) begin
          for (int p = 0; p < FEAT_BUF_SIZE; p++) begin
            // plane b carries weight 2**b
            acc = acc + (result_t'($countones(patch_i[b][r][p] & mask)) << b);
          end
        end
      end
      col_sum[c] = acc;
    end
  end

  // all columns latched together on the weight handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int c = 0; c < NR_COLUMN; c++) res_q[c] <= '0;
    end else if (clear_i) begin
      for (int c = 0; c < NR_COLUMN; c++) res_q[c] <= '0;
    end else if (ctrl.compute_fire) begin
      for (int c = 0; c < NR_COLUMN; c++) res_q[c] <= col_sum[c];
    end
  end

  // output mux, column 0 first
  assign conv_data_o = res_q[ctrl.col_idx];

endmodule

/* hw/rbe_engine_top.sv */
////////////////////
// rbe engine top
// feature and weight FIFOs, control FSM, patch buffer and binconv array
////////////////////

`timescale 1ns/1ps

module rbe_engine_top #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  fs_full_i,
  input  rbe_pkg::col_en_t      col_en_i,
  // feature stream, one bit plane of one row per beat
  input  logic                  feat_valid_i,
  input  rbe_pkg::feat_beat_t   feat_data_i,
  output logic                  feat_ready_o,
  // weight stream, one word per patch
  input  logic                  weight_valid_i,
  input  rbe_pkg::weight_word_t weight_data_i,
  output logic                  weight_ready_o,
  // result stream, one column per beat
  output logic                  conv_valid_o,
  output rbe_pkg::result_t      conv_data_o,
  output logic                  conv_last_o,
  input  logic                  conv_ready_i,
  output logic                  busy_o
);
  import rbe_pkg::*;

  engine_ctrl_if ctrl_if ();

  logic         feat_fifo_valid, feat_pop;
  feat_beat_t   feat_fifo_data;
  logic         weight_fifo_valid, weight_pop;
  weight_word_t weight_fifo_data;
  patch_t       patch;

  ////////////////////
  // input buffering
  ////////////////////
  stream_fifo #(.T(feat_beat_t), .DEPTH(FIFO_DEPTH)) feat_fifo_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
    .push_valid_i(feat_valid_i), .push_data_i(feat_data_i), .push_ready_o(feat_ready_o),
    .pop_valid_o(feat_fifo_valid), .pop_data_o(feat_fifo_data), .pop_ready_i(feat_pop)
  );

  stream_fifo #(.T(weight_word_t), .DEPTH(FIFO_DEPTH)) weight_fifo_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
    .push_valid_i(weight_valid_i), .push_data_i(weight_data_i),
    .push_ready_o(weight_ready_o),
    .pop_valid_o(weight_fifo_valid), .pop_data_o(weight_fifo_data),
    .pop_ready_i(weight_pop)
  );

  ////////////////////
  // control
  ////////////////////
  engine_ctrl engine_ctrl_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
    .fs_full_i(fs_full_i), .col_en_i(col_en_i),
    .feat_valid_i(feat_fifo_valid), .feat_pop_o(feat_pop),
    .weight_valid_i(weight_fifo_valid), .weight_pop_o(weight_pop),
    .conv_ready_i(conv_ready_i), .conv_valid_o(conv_valid_o),
    .conv_last_o(conv_last_o), .busy_o(busy_o), .ctrl(ctrl_if.ctrl)
  );

  patch_counter patch_counter_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i), .ctrl(ctrl_if.cnt)
  );

  // datapath
  patch_buffer patch_buffer_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
    .beat_i(feat_fifo_data), .ctrl(ctrl_if.dp), .patch_o(patch)
  );

  binconv_array binconv_array_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
    .patch_i(patch), .weight_i(weight_fifo_data), .ctrl(ctrl_if.dp),
    .conv_data_o(conv_data_o)
  );

  // a stalled result stays on the bus unchanged
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    conv_valid_o && !conv_ready_i |=>
      conv_valid_o && $stable(conv_data_o) && $stable(conv_last_o));

endmodule

/* test/tb_clock.sv */
////////////////////
// testbench clock
// free running clock, period in ns
////////////////////

`timescale 1ns/1ps

module tb_clock #(
  parameter int unsigned PERIOD = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    // runs until the testbench ends the simulation
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

/* test/tb_rbe_engine.sv */
////////////////////
// rbe engine testbench
// table-driven patches checked against a masked popcount model
////////////////////

`timescale 1ns/1ps

module tb_rbe_engine;
  import rbe_pkg::*;

  localparam int NR_TESTS = 6;
  localparam int NR_BEATS = int'(BLOCK_SIZE * FEAT_BUF_SIZE);
  localparam int TIMEOUT  = 200;

  logic         clk_i;
  logic         rst_ni;
  logic         clear_i;
  logic         fs_full_i;
  col_en_t      col_en_i;
  logic         feat_valid_i;
  feat_beat_t   feat_data_i;
  logic         feat_ready_o;
  logic         weight_valid_i;
  weight_word_t weight_data_i;
  logic         weight_ready_o;
  logic         conv_valid_o;
  result_t      conv_data_o;
  logic         conv_last_o;
  logic         conv_ready_i;
  logic         busy_o;

  ////////////////////
  // stimulus table
  ////////////////////
  // one row per patch with beats row-major and bit plane innermost
  string        name_tbl   [NR_TESTS];
  logic         fs_tbl     [NR_TESTS];
  col_en_t      col_en_tbl [NR_TESTS];
  feat_beat_t   beat_tbl   [NR_TESTS][NR_BEATS];
  weight_word_t weight_tbl [NR_TESTS];
  // conv_ready pattern with one bit per cycle from the lsb
  logic [7:0]   ready_tbl  [NR_TESTS];
  logic         wfirst_tbl [NR_TESTS];
  logic         clear_tbl  [NR_TESTS];
  result_t      exp_tbl    [NR_TESTS][NR_COLUMN];
  logic [31:0]  lcg_state;

  tb_clock #(.PERIOD(100)) tb_clock_inst (.clk_o(clk_i));

  rbe_engine_top #(.FIFO_DEPTH(2)) rbe_engine_top_inst (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper lcg bits are the better mixed ones
  function automatic feat_beat_t rand_beat();
    logic [31:0] v;
    v = lcg_next();
    return v[31:20];
  endfunction

  function automatic weight_word_t rand_weight();
    logic [31:0] v;
    v = lcg_next();
    return v[27:16];
  endfunction

  // sum over active rows, pixels and planes of popcount(plane & mask) * 2**bit
  function automatic result_t expected_sum(int t, int c);
    int            span;
    int            acc;
    logic [TP-1:0] mask;
    span = fs_tbl[t] ? int'(FEAT_BUF_SIZE) : int'(FEAT_BUF_MIN);
    mask = col_en_tbl[t][c] ? weight_tbl[t][c] : '0;
    acc  = 0;
    for (int r = 0; r < span; r++) begin
      for (int b = 0; b < int'(BLOCK_SIZE); b++) begin
        for (int p = 0; p < span; p++) begin
          acc += $countones(beat_tbl[t][r * int'(BLOCK_SIZE) + b][p] & mask) << b;
        end
      end
    end
    return result_t'(acc);
  endfunction

  task automatic fill_table();
    name_tbl   = '{"full_all", "reduced", "col_mask", "backpressure", "after_bp", "clear_mid"};
    fs_tbl     = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
    col_en_tbl = '{3'b111, 3'b111, 3'b101, 3'b111, 3'b110, 3'b111};
    ready_tbl  = '{8'hff, 8'hff, 8'hff, 8'b1001_0010, 8'hff, 8'hff};
    wfirst_tbl = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    clear_tbl  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    for (int t = 0; t < NR_TESTS; t++) begin
      for (int i = 0; i < NR_BEATS; i++) beat_tbl[t][i] = rand_beat();
      // channel 0 always set so no column mask is empty by chance
      weight_tbl[t] = rand_weight() | 12'h111;
      for (int c = 0; c < int'(NR_COLUMN); c++) exp_tbl[t][c] = expected_sum(t, c);
    end
  endtask

  ////////////////////
  // checks
  ////////////////////
  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_result(input string name, input result_t exp, input result_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // called on a falling edge and returns on the falling edge after the transfer
  task automatic push_feat(input string name, input feat_beat_t beat);
    int cnt;
    cnt = 0;
    feat_valid_i = 1'b1;
    feat_data_i  = beat;
    while (!feat_ready_o) begin
      @(negedge clk_i);
      cnt++;
      if (cnt > TIMEOUT) begin
        $display("%s: feature beat was not accepted in time", name);
        abort_run();
      end
    end
    @(negedge clk_i);
    feat_valid_i = 1'b0;
  endtask

  task automatic push_weight(input string name, input weight_word_t word);
    int cnt;
    cnt = 0;
    weight_valid_i = 1'b1;
    weight_data_i  = word;
    while (!weight_ready_o) begin
      @(negedge clk_i);
      cnt++;
      if (cnt > TIMEOUT) begin
        $display("%s: weight word was not accepted in time", name);
        abort_run();
      end
    end
    @(negedge clk_i);
    weight_valid_i = 1'b0;
  endtask

  // data and last are checked on every valid cycle including stalled ones
  task automatic collect_results(input int t);
    int idx;
    int k;
    int cnt;
    idx = 0;
    k   = 0;
    cnt = 0;
    while (idx < int'(NR_COLUMN)) begin
      conv_ready_i = ready_tbl[t][k % 8];
      k++;
      if (conv_valid_o) begin
        check_result($sformatf("%s/col%0d", name_tbl[t], idx), exp_tbl[t][idx], conv_data_o);
        check_flag($sformatf("%s/last%0d", name_tbl[t], idx),
          idx == int'(NR_COLUMN) - 1, conv_last_o);
        // draining counts as busy
        check_flag($sformatf("%s/busy%0d", name_tbl[t], idx), 1'b1, busy_o);
        if (conv_ready_i) idx++;
      end
      cnt++;
      if (cnt > TIMEOUT) begin
        $display("%s: result %0d did not arrive in time", name_tbl[t], idx);
        abort_run();
      end
      @(negedge clk_i);
    end
    conv_ready_i = 1'b0;
  endtask

  task automatic run_patch(input int t);
    int nbeats;
    nbeats    = fs_tbl[t] ? NR_BEATS : int'(BLOCK_SIZE * FEAT_BUF_MIN);
    fs_full_i = fs_tbl[t];
    col_en_i  = col_en_tbl[t];
    if (clear_tbl[t]) begin
      // abandon a partial patch of unrelated data
      for (int i = 0; i < 3; i++) push_feat(name_tbl[t], rand_beat());
      check_flag({name_tbl[t], "/busy_mid"}, 1'b1, busy_o);
      clear_i = 1'b1;
      @(negedge clk_i);
      clear_i = 1'b0;
      check_flag({name_tbl[t], "/busy_clear"}, 1'b0, busy_o);
    end
    if (wfirst_tbl[t]) push_weight(name_tbl[t], weight_tbl[t]);
    for (int i = 0; i < nbeats; i++) begin
      push_feat(name_tbl[t], beat_tbl[t][i]);
      // mode is sampled on the first beat so later input changes have no effect
      if (i == 1) begin
        fs_full_i = !fs_tbl[t];
        col_en_i  = ~col_en_tbl[t];
      end
    end
    if (!wfirst_tbl[t]) push_weight(name_tbl[t], weight_tbl[t]);
    collect_results(t);
    // back in gather with the counters at zero
    check_flag({name_tbl[t], "/busy_idle"}, 1'b0, busy_o);
  endtask

  initial begin
    lcg_state      = 32'h141b_f1fb;
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    fs_full_i      = 1'b0;
    col_en_i       = '0;
    feat_valid_i   = 1'b0;
    feat_data_i    = '0;
    weight_valid_i = 1'b0;
    weight_data_i  = '0;
    conv_ready_i   = 1'b0;
    fill_table();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("reset/feat_ready", 1'b1, feat_ready_o);
    check_flag("reset/weight_ready", 1'b1, weight_ready_o);
    check_flag("reset/conv_valid", 1'b0, conv_valid_o);
    check_flag("reset/busy", 1'b0, busy_o);
    for (int t = 0; t < NR_TESTS; t++) run_patch(t);
    $display("Simulation passed");
    $finish;
  end

endmodule

/* all.f */
hw/rbe_pkg.sv
hw/engine_ctrl_if.sv
hw/stream_fifo.sv
hw/patch_counter.sv
hw/engine_ctrl.sv
hw/patch_buffer.sv
hw/binconv_array.sv
hw/rbe_engine_top.sv
test/tb_clock.sv
test/tb_rbe_engine.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the rbe engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module tb_rbe_engine -o sim_rbe_engine \
  && ./obj_dir/sim_rbe_engine 2>&1 | tee sim.log
# the log decides the outcome
grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log \
  && { echo "run failed"; exit 1; } \
  || echo "run ok"
